//--- logic/tetris_pkg.sv
`default_nettype none

package tetris_pkg;

    // Default playfield size
    localparam int GRID_ROWS = 20;
    localparam int GRID_COLS = 10;

    localparam int SPAWN_COL = 3; // Left edge of the 4x4 box at spawn

    typedef enum logic [2:0] {
        PIECE_I,
        PIECE_O,
        PIECE_L,
        PIECE_J,
        PIECE_S,
        PIECE_Z,
        PIECE_T
    } piece_t;

    typedef enum logic [1:0] {
        ST_SPAWN,
        ST_FALLING,
        ST_LANDED,
        ST_GAMEOVER
    } game_state_t;

    // 4x4 occupancy box, bit [4*r + c] is box row r, box column c
    function automatic logic [15:0] piece_shape(input piece_t p);
        case (p)
            PIECE_I: return 16'h1111; // Vertical bar in box column 0
            PIECE_O: return 16'h0033;
            PIECE_L: return 16'h0311;
            PIECE_J: return 16'h0322;
            PIECE_S: return 16'h0036;
            PIECE_Z: return 16'h0063;
            PIECE_T: return 16'h0072; // Nub on top, three cells below
            default: return 16'h0000;
        endcase
    endfunction

    // Fixed rotating order, T wraps back to I
    function automatic piece_t piece_next(input piece_t p);
        return (p == PIECE_T) ? PIECE_I : piece_t'(p + 3'd1);
    endfunction

endpackage

`default_nettype wire

//--- logic/key_sync.sv
`timescale 1ns/1ps
`default_nettype none

module key_sync (
    input  logic clk,
    input  logic reset,
    input  logic key,
    output logic strobe
);

    logic sync_1;
    logic sync_2;
    logic last_level; // Level seen one cycle earlier

    // Two flops against metastability
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sync_1 <= 1'b0;
            sync_2 <= 1'b0;
        end else begin
            sync_1 <= key;
            sync_2 <= sync_1;
        end
    end

    // Rising edge gives a single registered pulse
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            last_level <= 1'b0;
            strobe     <= 1'b0;
        end else begin
            last_level <= sync_2;
            strobe     <= sync_2 & ~last_level;
        end
    end

endmodule

`default_nettype wire

//--- logic/piece_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module piece_sequencer (
    input  logic              clk,
    input  logic              reset,
    input  logic              load_piece,
    input  logic              restart,
    output tetris_pkg::piece_t piece_type
);

    import tetris_pkg::*;

    logic first_spawn; // Set until the first piece of a game is loaded

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            piece_type  <= PIECE_I;
            first_spawn <= 1'b1;
        end else if (restart) begin
            piece_type  <= PIECE_I;  // New game starts over
            first_spawn <= 1'b1;
        end else if (load_piece) begin
            first_spawn <= 1'b0;
            if (!first_spawn) begin
                piece_type <= piece_next(piece_type);
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/piece_mover.sv
`timescale 1ns/1ps
`default_nettype none

module piece_mover #(
    parameter int rows = tetris_pkg::GRID_ROWS,
    parameter int cols = tetris_pkg::GRID_COLS
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       load_piece,
    input  logic                       step_down,
    input  logic                       shift_left,
    input  logic                       shift_right,
    input  tetris_pkg::piece_t         piece_type,
    input  logic [rows-1:0][cols-1:0]  stored_grid,
    output logic [rows-1:0][cols-1:0]  active_mask,
    output logic                       down_blocked,
    output logic                       spawn_blocked
);

    import tetris_pkg::*;

    localparam int ROW_W = $clog2(rows);
    localparam int COL_W = $clog2(cols);

    logic [ROW_W-1:0] row_pos;  // Top row of the box
    logic [COL_W-1:0] col_pos;  // Left column of the box
    logic [15:0]      cur_shape;
    logic [15:0]      spawn_shape;
    logic             left_blocked;
    logic             right_blocked;

    // True when any filled box cell is off the grid or on a stored cell
    function automatic logic collides(
        input int                          top,
        input int                          left,
        input logic [15:0]                 shape,
        input logic [rows-1:0][cols-1:0]   grid
    );
        logic hit;
        int   r_abs;
        int   c_abs;
        hit = 1'b0;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                r_abs = top + r;
                c_abs = left + c;
                if (shape[4*r + c]) begin
                    if (r_abs >= rows || c_abs < 0 || c_abs >= cols) begin
                        hit = 1'b1;  // Floor or wall
                    end else if (grid[r_abs][c_abs]) begin
                        hit = 1'b1;
                    end
                end
            end
        end
        return hit;
    endfunction

    assign cur_shape = piece_shape(piece_type);

    // The type advances on the same edge that loads the spawn position,
    // so the spawn test looks at the successor. The first spawn of a game
    // always meets an empty grid, where either answer is the same.
    assign spawn_shape = piece_shape(piece_next(piece_type));

    always_comb begin
        down_blocked  = collides(int'(row_pos) + 1, int'(col_pos), cur_shape, stored_grid);
        left_blocked  = collides(int'(row_pos), int'(col_pos) - 1, cur_shape, stored_grid);
        right_blocked = collides(int'(row_pos), int'(col_pos) + 1, cur_shape, stored_grid);
        spawn_blocked = collides(0, SPAWN_COL, spawn_shape, stored_grid);
    end

    // Position update, down has priority over sideways
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            row_pos <= '0;
            col_pos <= COL_W'(SPAWN_COL);
        end else if (load_piece) begin
            row_pos <= '0;
            col_pos <= COL_W'(SPAWN_COL);
        end else if (step_down) begin
            if (!down_blocked) begin
                row_pos <= row_pos + 1'b1;
            end
        end else if (shift_left) begin
            if (!left_blocked) begin
                col_pos <= col_pos - 1'b1;
            end
        end else if (shift_right) begin
            if (!right_blocked) begin
                col_pos <= col_pos + 1'b1;
            end
        end
    end

    // Expand the box into grid coordinates
    always_comb begin
        active_mask = '0;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                if (cur_shape[4*r + c] && (int'(row_pos) + r < rows)
                        && (int'(col_pos) + c < cols)) begin
                    active_mask[int'(row_pos) + r][int'(col_pos) + c] = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/tetris_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module tetris_fsm #(
    parameter int rows = tetris_pkg::GRID_ROWS,
    parameter int cols = tetris_pkg::GRID_COLS
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       drop_tick,
    input  logic                       left_strobe,
    input  logic                       right_strobe,
    input  logic                       new_game_strobe,
    input  logic [rows-1:0][cols-1:0]  active_mask,
    input  logic                       down_blocked,
    input  logic                       spawn_blocked,
    output logic                       load_piece,
    output logic                       step_down,
    output logic                       shift_left,
    output logic                       shift_right,
    output logic                       restart,
    output logic                       game_over,
    output logic [rows-1:0][cols-1:0]  stored_grid,
    output logic [rows-1:0][cols-1:0]  display
);

    import tetris_pkg::*;

    game_state_t state;
    game_state_t state_next;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= ST_SPAWN;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            ST_SPAWN:    state_next = spawn_blocked ? ST_GAMEOVER : ST_FALLING;
            ST_FALLING: begin
                if (drop_tick && down_blocked) begin
                    state_next = ST_LANDED;  // Tick found the piece resting
                end
            end
            ST_LANDED:   state_next = ST_SPAWN;
            ST_GAMEOVER: state_next = new_game_strobe ? ST_SPAWN : ST_GAMEOVER;
            default:     state_next = ST_SPAWN;
        endcase
    end

    // Control outputs
    assign load_piece  = (state == ST_SPAWN);
    assign game_over   = (state == ST_GAMEOVER);
    assign restart     = game_over & new_game_strobe;
    assign step_down   = (state == ST_FALLING) & drop_tick & ~down_blocked;
    assign shift_left  = (state == ST_FALLING) & left_strobe & ~drop_tick;  // Tick wins
    assign shift_right = (state == ST_FALLING) & right_strobe & ~drop_tick;

    // Permanent cells, merged once per landing
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            stored_grid <= '0;
        end else if (restart) begin
            stored_grid <= '0;
        end else if (state == ST_LANDED) begin
            stored_grid <= stored_grid | active_mask;
        end
    end

    always_comb begin
        case (state)
            ST_FALLING, ST_LANDED: display = stored_grid | active_mask;
            default:               display = stored_grid;  // No live piece shown
        endcase
    end

endmodule

`default_nettype wire

//--- logic/tetris_top.sv
`timescale 1ns/1ps
`default_nettype none

module tetris_top #(
    parameter int rows = tetris_pkg::GRID_ROWS,
    parameter int cols = tetris_pkg::GRID_COLS
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       left_key,
    input  logic                       right_key,
    input  logic                       new_game_key,
    input  logic                       drop_tick,
    output logic [rows-1:0][cols-1:0]  display,
    output tetris_pkg::piece_t         piece_type,
    output logic                       spawn_pulse,
    output logic                       game_over
);

    logic                      left_strobe;
    logic                      right_strobe;
    logic                      new_game_strobe;
    logic                      load_piece;
    logic                      step_down;
    logic                      shift_left;
    logic                      shift_right;
    logic                      restart;
    logic                      down_blocked;
    logic                      spawn_blocked;
    logic [rows-1:0][cols-1:0] stored_grid;
    logic [rows-1:0][cols-1:0] active_mask;

    assign spawn_pulse = load_piece;

    // Raw keys into one-cycle strobes
    key_sync u_left_sync (.clk(clk), .reset(reset), .key(left_key), .strobe(left_strobe));
    key_sync u_right_sync (.clk(clk), .reset(reset), .key(right_key), .strobe(right_strobe));
    key_sync u_new_game_sync (
        .clk    (clk),
        .reset  (reset),
        .key    (new_game_key),
        .strobe (new_game_strobe)
    );

    piece_sequencer u_sequencer (
        .clk        (clk),
        .reset      (reset),
        .load_piece (load_piece),
        .restart    (restart),
        .piece_type (piece_type)
    );

    piece_mover #(.rows(rows), .cols(cols)) u_mover (
        .clk           (clk),
        .reset         (reset),
        .load_piece    (load_piece),
        .step_down     (step_down),
        .shift_left    (shift_left),
        .shift_right   (shift_right),
        .piece_type    (piece_type),
        .stored_grid   (stored_grid),
        .active_mask   (active_mask),
        .down_blocked  (down_blocked),
        .spawn_blocked (spawn_blocked)
    );

    tetris_fsm #(.rows(rows), .cols(cols)) u_fsm (
        .clk             (clk),
        .reset           (reset),
        .drop_tick       (drop_tick),
        .left_strobe     (left_strobe),
        .right_strobe    (right_strobe),
        .new_game_strobe (new_game_strobe),
        .active_mask     (active_mask),
        .down_blocked    (down_blocked),
        .spawn_blocked   (spawn_blocked),
        .load_piece      (load_piece),
        .step_down       (step_down),
        .shift_left      (shift_left),
        .shift_right     (shift_right),
        .restart         (restart),
        .game_over       (game_over),
        .stored_grid     (stored_grid),
        .display         (display)
    );

endmodule

`default_nettype wire

//--- verif/tetris_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tetris_checker #(
    parameter int rows = tetris_pkg::GRID_ROWS,
    parameter int cols = tetris_pkg::GRID_COLS
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      left_key,
    input  logic                      right_key,
    input  logic                      new_game_key,
    input  logic                      drop_tick,
    input  logic [rows-1:0][cols-1:0] display,
    input  tetris_pkg::piece_t        piece_type,
    input  logic                      spawn_pulse,
    input  logic                      game_over,
    output int                        error_count
);

    import tetris_pkg::*;

    game_state_t               m_state;
    piece_t                    m_type;
    logic                      m_first;  // Next spawn keeps the type
    int                        m_row;
    int                        m_col;
    logic [rows-1:0][cols-1:0] m_grid;
    logic [3:0]                left_hist;  // Bit n holds the level n+1 edges back
    logic [3:0]                right_hist;
    logic [3:0]                new_hist;

    // Box rows top to bottom, box column 0 is the left bit of each nibble
    function automatic logic [3:0] box_row(input piece_t p, input int r);
        logic [15:0] pattern;
        case (p)
            PIECE_I: pattern = 16'b1000_1000_1000_1000;
            PIECE_O: pattern = 16'b1100_1100_0000_0000;
            PIECE_L: pattern = 16'b1000_1000_1100_0000;
            PIECE_J: pattern = 16'b0100_0100_1100_0000;
            PIECE_S: pattern = 16'b0110_1100_0000_0000;
            PIECE_Z: pattern = 16'b1100_0110_0000_0000;
            PIECE_T: pattern = 16'b0100_1110_0000_0000;
            default: pattern = 16'h0000;
        endcase
        return pattern[15 - 4*r -: 4];
    endfunction

    function automatic logic [rows-1:0][cols-1:0] piece_cells(
        input piece_t p,
        input int     top,
        input int     left
    );
        logic [rows-1:0][cols-1:0] cells;
        logic [3:0]                line;
        cells = '0;
        for (int r = 0; r < 4; r++) begin
            line = box_row(p, r);
            for (int c = 0; c < 4; c++) begin
                if (line[3-c] && top + r < rows && left + c >= 0 && left + c < cols) begin
                    cells[top + r][left + c] = 1'b1;
                end
            end
        end
        return cells;
    endfunction

    // Legal when every cell is inside the walls, above the floor and free
    function automatic logic fits(
        input piece_t                    p,
        input int                        top,
        input int                        left,
        input logic [rows-1:0][cols-1:0] grid
    );
        logic       ok;
        logic [3:0] line;
        ok = 1'b1;
        for (int r = 0; r < 4; r++) begin
            line = box_row(p, r);
            for (int c = 0; c < 4; c++) begin
                if (line[3-c]) begin
                    if (top + r >= rows || left + c < 0 || left + c >= cols) begin
                        ok = 1'b0;
                    end else if (grid[top + r][left + c]) begin
                        ok = 1'b0;
                    end
                end
            end
        end
        return ok;
    endfunction

    function automatic piece_t following(input piece_t p);
        return (p == PIECE_T) ? PIECE_I : piece_t'(int'(p) + 1);
    endfunction

    function automatic logic [rows-1:0][cols-1:0] expected_display();
        if (m_state == ST_FALLING || m_state == ST_LANDED) begin
            return m_grid | piece_cells(m_type, m_row, m_col);
        end
        return m_grid;  // No live piece
    endfunction

    task automatic clear_model();
        m_state    = ST_SPAWN;
        m_type     = PIECE_I;
        m_first    = 1'b1;
        m_row      = 0;
        m_col      = SPAWN_COL;
        m_grid     = '0;
        left_hist  = '0;
        right_hist = '0;
        new_hist   = '0;
    endtask

    // One clock edge of the game
    task automatic advance_model(input logic go_left, input logic go_right, input logic again);
        case (m_state)
            ST_SPAWN: begin
                if (!m_first) begin
                    m_type = following(m_type);
                end
                m_first = 1'b0;
                m_row   = 0;
                m_col   = SPAWN_COL;
                m_state = fits(m_type, 0, SPAWN_COL, m_grid) ? ST_FALLING : ST_GAMEOVER;
            end
            ST_FALLING: begin
                if (drop_tick) begin  // Tick beats a shift
                    if (fits(m_type, m_row + 1, m_col, m_grid)) begin
                        m_row = m_row + 1;
                    end else begin
                        m_state = ST_LANDED;
                    end
                end else if (go_left) begin
                    if (fits(m_type, m_row, m_col - 1, m_grid)) begin
                        m_col = m_col - 1;
                    end
                end else if (go_right) begin
                    if (fits(m_type, m_row, m_col + 1, m_grid)) begin
                        m_col = m_col + 1;
                    end
                end
            end
            ST_LANDED: begin
                m_grid  = m_grid | piece_cells(m_type, m_row, m_col);
                m_state = ST_SPAWN;
            end
            default: begin
                if (again) begin
                    m_grid  = '0;
                    m_type  = PIECE_I;
                    m_first = 1'b1;
                    m_state = ST_SPAWN;
                end
            end
        endcase
    endtask

    task automatic log_mismatch(input string name, input string expected, input string actual);
        error_count++;
        $display("ERR %0t %s expected %s actual %s", $time, name, expected, actual);
    endtask

    initial begin
        error_count = 0;
        clear_model();
    end

    // A key that rose at edge k acts at edge k+3
    always @(posedge clk or posedge reset) begin
        if (reset) begin
            clear_model();
        end else begin
            advance_model(left_hist[2] & ~left_hist[3], right_hist[2] & ~right_hist[3],
                          new_hist[2] & ~new_hist[3]);
            left_hist  = {left_hist[2:0], left_key};
            right_hist = {right_hist[2:0], right_key};
            new_hist   = {new_hist[2:0], new_game_key};
        end
    end

    always @(negedge clk) begin
        if (!reset) begin
            if (display !== expected_display()) begin
                log_mismatch("display", $sformatf("%h", expected_display()),
                             $sformatf("%h", display));
            end
            if (piece_type !== m_type) begin
                log_mismatch("piece_type", m_type.name(), $sformatf("%0d", piece_type));
            end
            if (game_over !== (m_state == ST_GAMEOVER)) begin
                log_mismatch("game_over", $sformatf("%b", m_state == ST_GAMEOVER),
                             $sformatf("%b", game_over));
            end
            if (spawn_pulse !== (m_state == ST_SPAWN)) begin
                log_mismatch("spawn_pulse", $sformatf("%b", m_state == ST_SPAWN),
                             $sformatf("%b", spawn_pulse));
            end
        end
    end

endmodule

`default_nettype wire

//--- verif/tb_tetris.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tetris;

    import tetris_pkg::*;

    localparam int rows     = GRID_ROWS;
    localparam int cols     = GRID_COLS;
    localparam int max_wait = 200;  // Cycles allowed for one wait

    logic                      clk;
    logic                      reset;
    logic                      left_key;
    logic                      right_key;
    logic                      new_game_key;
    logic                      drop_tick;
    logic [rows-1:0][cols-1:0] display;
    piece_t                    piece_type;
    logic                      spawn_pulse;
    logic                      game_over;
    int                        mismatch_count;
    int                        timeout_count;
    int                        piece_count;
    int                        press_count;

    always #4 clk = ~clk;

    tetris_top #(.rows(rows), .cols(cols)) uut (
        .clk          (clk),
        .reset        (reset),
        .left_key     (left_key),
        .right_key    (right_key),
        .new_game_key (new_game_key),
        .drop_tick    (drop_tick),
        .display      (display),
        .piece_type   (piece_type),
        .spawn_pulse  (spawn_pulse),
        .game_over    (game_over)
    );

    tetris_checker #(.rows(rows), .cols(cols)) watcher (
        .clk          (clk),
        .reset        (reset),
        .left_key     (left_key),
        .right_key    (right_key),
        .new_game_key (new_game_key),
        .drop_tick    (drop_tick),
        .display      (display),
        .piece_type   (piece_type),
        .spawn_pulse  (spawn_pulse),
        .game_over    (game_over),
        .error_count  (mismatch_count)
    );

    task automatic end_run();
        $display("Mismatches %0d, timeouts %0d", mismatch_count, timeout_count);
        if (mismatch_count + timeout_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        timeout_count++;
        end_run();
    endtask

    task automatic wait_for_spawn();
        int count;
        count = 0;
        while (!spawn_pulse && count < max_wait) begin
            @(negedge clk);
            count++;
        end
        if (!spawn_pulse) report_timeout("a piece spawn");
    endtask

    // Held for 3 cycles and followed by 8 quiet cycles
    task automatic press_key(input int which);
        case (which)
            0:       left_key = 1'b1;
            1:       right_key = 1'b1;
            default: new_game_key = 1'b1;
        endcase
        repeat (3) @(negedge clk);
        left_key     = 1'b0;
        right_key    = 1'b0;
        new_game_key = 1'b0;
        repeat (8) @(negedge clk);
    endtask

    // Gravity tick followed by 8 quiet cycles that are watched for a landing
    task automatic give_tick(output logic landed);
        landed    = 1'b0;
        drop_tick = 1'b1;
        @(negedge clk);
        drop_tick = 1'b0;
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            if (spawn_pulse || game_over) landed = 1'b1;
        end
    endtask

    // Ticks until the next spawn or game over
    task automatic drop_piece();
        int   ticks;
        logic done;
        ticks = 0;
        done  = 1'b0;
        while (!done && ticks < rows + 4) begin
            give_tick(done);
            ticks++;
        end
        if (!done) report_timeout("the piece to land");
    endtask

    // Brings the piece down near the stack so that shifts meet stored cells
    task automatic lower_piece(input int steps);
        logic landed;
        landed = 1'b0;
        for (int i = 0; i < steps && !landed; i++) begin
            give_tick(landed);
        end
    endtask

    task automatic start_new_game();
        new_game_key = 1'b1;
        wait_for_spawn();
        new_game_key = 1'b0;
        repeat (8) @(negedge clk);
    endtask

    initial begin
        clk           = 1'b0;
        reset         = 1'b1;
        left_key      = 1'b0;
        right_key     = 1'b0;
        new_game_key  = 1'b0;
        drop_tick     = 1'b0;
        timeout_count = 0;
        void'($urandom(89725));
        repeat (16) @(negedge clk);
        reset = 1'b0;
        wait_for_spawn();
        repeat (8) @(negedge clk);

        // First I piece against both walls and down to the floor
        repeat (5) press_key(0);
        repeat (cols + 2) press_key(1);
        drop_piece();

        // Random sideways moves at the top and low beside the stack
        piece_count = 9 + int'($urandom % 4);
        for (int p = 0; p < piece_count && !game_over; p++) begin
            press_count = int'($urandom % 7);
            repeat (press_count) press_key(int'($urandom % 2));
            lower_piece(rows - 6 + int'($urandom % 3));
            press_count = int'($urandom % 7);
            repeat (press_count) press_key(int'($urandom % 2));
            drop_piece();
        end

        // Pile up in the middle until a spawn overlaps
        piece_count = 0;
        while (!game_over && piece_count < 60) begin
            drop_piece();
            piece_count++;
        end
        if (!game_over) report_timeout("game over");

        press_key(0);  // Display stays frozen
        drop_piece();
        press_key(1);
        start_new_game();
        repeat (3) drop_piece();
        end_run();
    end

endmodule

`default_nettype wire

//--- build.f
logic/tetris_pkg.sv
logic/key_sync.sv
logic/piece_sequencer.sv
logic/piece_mover.sv
logic/tetris_fsm.sv
logic/tetris_top.sv
verif/tetris_checker.sv
verif/tb_tetris.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the testbench with Verilator, from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f build.f --top-module tb_tetris \
    -Mdir obj_dir -o sim_tetris
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tetris > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "No errors" sim.log; then
    exit 0
fi
exit 1
